// ==== basicTypes.sv ====
package basicTypes;

  localparam int xlen = 32;

  localparam int imemDepth = 64;
  localparam int dmemDepth = 64;

  // Word index widths for the two memories, addressed by byte
  localparam int imemIdxBits = $clog2(imemDepth);
  localparam int dmemIdxBits = $clog2(dmemDepth);

  typedef logic [xlen-1:0] wordT;

  typedef logic [4:0] regAddrT;

  // Where the second ALU operand comes from
  typedef enum logic [1:0] {
    OP_TYPE_REG,
    OP_TYPE_IMM,
    OP_TYPE_NONE
  } opTypeE;

endpackage

// ==== pipelineTypes.sv ====
package pipelineTypes;

  // RV32I major opcodes
  typedef enum logic [6:0] {
    OP_REG    = 7'b0110011,
    OP_IMM    = 7'b0010011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_BRANCH = 7'b1100011
  } opcodeE;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT
  } aluOpE;

  typedef enum logic [1:0] {
    BYPASS_NONE,
    BYPASS_EXEC,  // EX/MEM result
    BYPASS_MEM    // MEM/WB result
  } bypassE;

  localparam int btbEntries = 8;
  localparam int btbIndexBits = $clog2(btbEntries);

endpackage

// ==== hazardController.sv ====
`timescale 1ns/10ps

module hazardController (
  input  basicTypes::opTypeE      decAluOp2Type,
  input  logic                    decUsesRs1,
  input  logic                    decIsStore,
  input  logic                    decIsBranch,
  input  basicTypes::regAddrT     decRs1Addr,
  input  basicTypes::regAddrT     decRs2Addr,
  input  basicTypes::regAddrT     exRdAddr,
  input  logic                    exWEnable,
  input  logic                    exIsForwardable,
  input  basicTypes::regAddrT     memRdAddr,
  input  logic                    memWEnable,
  input  logic                    memIsForwardable,
  input  logic                    exBranchTaken,
  input  logic                    exIsBranchTakenPredicted,
  input  basicTypes::wordT        exPredictedNextPc,
  input  basicTypes::wordT        exIrregPc,
  output pipelineTypes::bypassE   op1BypassCtrl,
  output pipelineTypes::bypassE   op2BypassCtrl,
  output logic                    isDataHazard,
  output logic                    isBranchPredictMiss
);

  logic isRs1DataHazard;
  logic isRs2DataHazard;
  logic usesRs2;

  // Nearest producer wins, so execute is checked before memory
  function automatic pipelineTypes::bypassE pickBypass(
    input  logic                used,
    input  basicTypes::regAddrT rs,
    output logic                hazard
  );
    pickBypass = pipelineTypes::BYPASS_NONE;
    hazard = 1'b0;
    if (used && rs != '0) begin
      if (exWEnable && rs == exRdAddr) begin
        if (exIsForwardable) pickBypass = pipelineTypes::BYPASS_EXEC;
        else hazard = 1'b1;  // Load still in execute
      end else if (memWEnable && rs == memRdAddr) begin
        if (memIsForwardable) pickBypass = pipelineTypes::BYPASS_MEM;
        else hazard = 1'b1;
      end
    end
  endfunction

  assign usesRs2 = decAluOp2Type == basicTypes::OP_TYPE_REG || decIsStore || decIsBranch;

  always_comb begin
    op1BypassCtrl = pickBypass(decUsesRs1, decRs1Addr, isRs1DataHazard);
    op2BypassCtrl = pickBypass(usesRs2, decRs2Addr, isRs2DataHazard);
  end

  assign isDataHazard = isRs1DataHazard || isRs2DataHazard;

  // A taken prediction to the wrong target is a miss as well
  always_comb begin
    if (exBranchTaken != exIsBranchTakenPredicted) begin
      isBranchPredictMiss = 1'b1;
    end else if (exBranchTaken && exIsBranchTakenPredicted &&
                 exPredictedNextPc != exIrregPc) begin
      isBranchPredictMiss = 1'b1;
    end else begin
      isBranchPredictMiss = 1'b0;
    end
  end

endmodule

// ==== branchPredictor.sv ====
`timescale 1ns/10ps

module branchPredictor (
  input  logic             clk,
  input  logic             rstN,
  input  basicTypes::wordT lookupPc,
  input  logic             updateEn,
  input  basicTypes::wordT updatePc,
  input  logic             updateTaken,
  input  basicTypes::wordT updateTarget,
  output logic             predTaken,
  output basicTypes::wordT predTarget
);

  logic [pipelineTypes::btbEntries-1:0] takenBits;
  logic [basicTypes::xlen-1:pipelineTypes::btbIndexBits+2] tagArr [pipelineTypes::btbEntries];
  basicTypes::wordT targetArr [pipelineTypes::btbEntries];

  logic [pipelineTypes::btbIndexBits-1:0] lookupIdx;
  logic [pipelineTypes::btbIndexBits-1:0] updateIdx;

  assign lookupIdx = lookupPc[pipelineTypes::btbIndexBits+1:2];
  assign updateIdx = updatePc[pipelineTypes::btbIndexBits+1:2];

  // Hit needs the taken bit and a matching tag
  assign predTaken = takenBits[lookupIdx] &&
                     tagArr[lookupIdx] == lookupPc[basicTypes::xlen-1:pipelineTypes::btbIndexBits+2];
  assign predTarget = predTaken ? targetArr[lookupIdx] : lookupPc + 4;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      takenBits <= '0;
    end else if (updateEn) begin
      takenBits[updateIdx] <= updateTaken;
    end
  end

  always_ff @(posedge clk) begin
    if (updateEn) begin
      tagArr[updateIdx] <= updatePc[basicTypes::xlen-1:pipelineTypes::btbIndexBits+2];
      targetArr[updateIdx] <= updateTarget;
    end
  end

endmodule

// ==== fetchStage.sv ====
`timescale 1ns/10ps

module fetchStage (
  input  logic             clk,
  input  logic             rstN,
  input  logic             run,
  input  logic             stall,
  input  logic             redirect,
  input  basicTypes::wordT redirectPc,
  input  logic             imemWrEn,
  input  basicTypes::wordT imemAddr,  // Byte address
  input  basicTypes::wordT imemData,
  input  logic             predTaken,
  input  basicTypes::wordT predTarget,
  output basicTypes::wordT lookupPc,
  output logic             ifValid,
  output basicTypes::wordT ifPc,
  output basicTypes::wordT ifInstr,
  output logic             ifPredTaken,
  output basicTypes::wordT ifPredTarget
);

  basicTypes::wordT pc;
  basicTypes::wordT nextPc;
  basicTypes::wordT imem [basicTypes::imemDepth];

  assign lookupPc = pc;

  // Redirect beats stall, stall beats prediction
  always_comb begin
    if (!run) nextPc = '0;
    else if (redirect) nextPc = redirectPc;
    else if (stall) nextPc = pc;
    else nextPc = predTarget;  // Already pc+4 when not predicted taken
  end

  always_ff @(posedge clk) begin
    if (imemWrEn && !run) imem[imemAddr[basicTypes::imemIdxBits+1:2]] <= imemData;
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc <= '0;
      ifValid <= 1'b0;
    end else begin
      pc <= nextPc;
      if (!run || redirect) ifValid <= 1'b0;
      else if (!stall) ifValid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      ifPc <= pc;
      ifInstr <= imem[pc[basicTypes::imemIdxBits+1:2]];
      ifPredTaken <= predTaken;
      ifPredTarget <= predTarget;
    end
  end

endmodule

// ==== decodeStage.sv ====
`timescale 1ns/10ps

module decodeStage (
  input  logic                  clk,
  input  logic                  rstN,
  input  logic                  stall,
  input  logic                  flush,
  input  logic                  ifValid,
  input  basicTypes::wordT      ifPc,
  input  basicTypes::wordT      ifInstr,
  input  logic                  ifPredTaken,
  input  basicTypes::wordT      ifPredTarget,
  input  pipelineTypes::bypassE op1BypassCtrl,
  input  pipelineTypes::bypassE op2BypassCtrl,
  input  logic                  wbEn,
  input  basicTypes::regAddrT   wbAddr,
  input  basicTypes::wordT      wbData,
  output basicTypes::opTypeE    decAluOp2Type,
  output logic                  decUsesRs1,
  output logic                  decIsStore,
  output logic                  decIsBranch,
  output basicTypes::regAddrT   decRs1Addr,
  output basicTypes::regAddrT   decRs2Addr,
  output logic                  idValid,
  output basicTypes::wordT      idPc,
  output pipelineTypes::aluOpE  idAluOp,
  output pipelineTypes::opcodeE idOpcode,
  output basicTypes::wordT      idRs1Data,
  output basicTypes::wordT      idRs2Data,
  output basicTypes::wordT      idImm,
  output basicTypes::regAddrT   idRdAddr,
  output logic                  idRdWrEn,
  output pipelineTypes::bypassE idByp1,
  output pipelineTypes::bypassE idByp2,
  output logic                  idPredTaken,
  output basicTypes::wordT      idPredTarget,
  output logic                  idBranchNe
);

  basicTypes::wordT regFile [32];
  basicTypes::regAddrT rdAddr;
  basicTypes::wordT imm;
  pipelineTypes::aluOpE aluOp;
  logic decOk;
  logic rdWrEn;
  logic [2:0] funct3;

  assign funct3 = ifInstr[14:12];
  assign rdAddr = ifInstr[11:7];
  assign decRs1Addr = ifInstr[19:15];
  assign decRs2Addr = ifInstr[24:20];

  always_comb begin
    decOk = 1'b0;
    aluOp = pipelineTypes::ALU_ADD;
    decAluOp2Type = basicTypes::OP_TYPE_IMM;
    decUsesRs1 = 1'b1;
    decIsStore = 1'b0;
    decIsBranch = 1'b0;
    rdWrEn = 1'b0;
    imm = {{20{ifInstr[31]}}, ifInstr[31:20]};
    case (ifInstr[6:0])
      pipelineTypes::OP_REG: begin
        decAluOp2Type = basicTypes::OP_TYPE_REG;
        rdWrEn = 1'b1;
        decOk = 1'b1;
        case (funct3)
          3'b000: aluOp = ifInstr[30] ? pipelineTypes::ALU_SUB : pipelineTypes::ALU_ADD;
          3'b010: aluOp = pipelineTypes::ALU_SLT;
          3'b100: aluOp = pipelineTypes::ALU_XOR;
          3'b110: aluOp = pipelineTypes::ALU_OR;
          3'b111: aluOp = pipelineTypes::ALU_AND;
          default: decOk = 1'b0;
        endcase
      end
      pipelineTypes::OP_IMM: begin
        rdWrEn = 1'b1;
        decOk = funct3 == 3'b000;  // ADDI only
      end
      pipelineTypes::OP_LOAD: begin
        rdWrEn = 1'b1;
        decOk = funct3 == 3'b010;
      end
      pipelineTypes::OP_STORE: begin
        decIsStore = 1'b1;
        imm = {{20{ifInstr[31]}}, ifInstr[31:25], ifInstr[11:7]};
        decOk = funct3 == 3'b010;
      end
      pipelineTypes::OP_BRANCH: begin
        decAluOp2Type = basicTypes::OP_TYPE_REG;
        decIsBranch = 1'b1;
        imm = {{19{ifInstr[31]}}, ifInstr[31], ifInstr[7], ifInstr[30:25],
               ifInstr[11:8], 1'b0};
        decOk = funct3[2:1] == 2'b00;  // BEQ or BNE
      end
      default: decOk = 1'b0;
    endcase
    // Bubbles and unknown words must not look like operand users
    if (!(ifValid && decOk)) begin
      decOk = 1'b0;
      decAluOp2Type = basicTypes::OP_TYPE_NONE;
      decUsesRs1 = 1'b0;
      decIsStore = 1'b0;
      decIsBranch = 1'b0;
      rdWrEn = 1'b0;
    end
    if (rdAddr == '0) rdWrEn = 1'b0;
  end

  // Write-through read so the writeback distance needs no bypass
  function automatic basicTypes::wordT readReg(input basicTypes::regAddrT addr);
    if (addr == '0) readReg = '0;
    else if (wbEn && wbAddr == addr) readReg = wbData;
    else readReg = regFile[addr];
  endfunction

  always_ff @(posedge clk) begin
    if (wbEn && wbAddr != '0) regFile[wbAddr] <= wbData;
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      idValid <= 1'b0;
      idRdWrEn <= 1'b0;
    end else if (stall || flush) begin
      idValid <= 1'b0;
      idRdWrEn <= 1'b0;
    end else begin
      idValid <= decOk;
      idRdWrEn <= rdWrEn;
    end
  end

  always_ff @(posedge clk) begin
    idPc <= ifPc;
    idAluOp <= aluOp;
    idOpcode <= pipelineTypes::opcodeE'(ifInstr[6:0]);
    idRs1Data <= readReg(decRs1Addr);
    idRs2Data <= readReg(decRs2Addr);
    idImm <= imm;
    idRdAddr <= rdAddr;
    idByp1 <= op1BypassCtrl;
    idByp2 <= op2BypassCtrl;
    idPredTaken <= ifPredTaken;
    idPredTarget <= ifPredTarget;
    idBranchNe <= funct3[0];
  end

endmodule

// ==== executeStage.sv ====
`timescale 1ns/10ps

module executeStage (
  input  logic                  clk,
  input  logic                  rstN,
  input  logic                  idValid,
  input  basicTypes::wordT      idPc,
  input  pipelineTypes::aluOpE  idAluOp,
  input  pipelineTypes::opcodeE idOpcode,
  input  basicTypes::wordT      idRs1Data,
  input  basicTypes::wordT      idRs2Data,
  input  basicTypes::wordT      idImm,
  input  basicTypes::regAddrT   idRdAddr,
  input  logic                  idRdWrEn,
  input  pipelineTypes::bypassE idByp1,
  input  pipelineTypes::bypassE idByp2,
  input  logic                  idPredTaken,
  input  basicTypes::wordT      idPredTarget,
  input  logic                  idBranchNe,
  input  basicTypes::wordT      exMemResult,
  input  basicTypes::wordT      memWbResult,
  output basicTypes::regAddrT   exRdAddr,
  output logic                  exWEnable,
  output logic                  exIsForwardable,
  output logic                  exBranchTaken,
  output logic                  exIsBranchTakenPredicted,
  output basicTypes::wordT      exPredictedNextPc,
  output basicTypes::wordT      exIrregPc,
  output logic                  exIsBranch,
  output logic                  emValid,
  output basicTypes::wordT      emPc,
  output basicTypes::wordT      emResult,
  output basicTypes::wordT      emStoreData,
  output logic                  emIsLoad,
  output logic                  emIsStore,
  output basicTypes::regAddrT   emRdAddr,
  output logic                  emRdWrEn
);

  basicTypes::wordT op1;
  basicTypes::wordT op2;
  basicTypes::wordT aluB;
  basicTypes::wordT aluOut;
  basicTypes::wordT seqPc;

  function automatic basicTypes::wordT bypassMux(
    input pipelineTypes::bypassE sel,
    input basicTypes::wordT      regData
  );
    case (sel)
      pipelineTypes::BYPASS_EXEC: bypassMux = exMemResult;
      pipelineTypes::BYPASS_MEM:  bypassMux = memWbResult;
      default:                    bypassMux = regData;
    endcase
  endfunction

  always_comb begin
    op1 = bypassMux(idByp1, idRs1Data);
    op2 = bypassMux(idByp2, idRs2Data);
  end

  assign aluB = (idOpcode == pipelineTypes::OP_REG) ? op2 : idImm;

  always_comb begin
    case (idAluOp)
      pipelineTypes::ALU_SUB: aluOut = op1 - aluB;
      pipelineTypes::ALU_AND: aluOut = op1 & aluB;
      pipelineTypes::ALU_OR:  aluOut = op1 | aluB;
      pipelineTypes::ALU_XOR: aluOut = op1 ^ aluB;
      pipelineTypes::ALU_SLT: aluOut = {{(basicTypes::xlen-1){1'b0}}, $signed(op1) < $signed(aluB)};
      default:                aluOut = op1 + aluB;  // Also the load/store address
    endcase
  end

  assign seqPc = idPc + 4;
  assign exIsBranch = idValid && idOpcode == pipelineTypes::OP_BRANCH;
  assign exBranchTaken = exIsBranch && ((op1 == op2) != idBranchNe);
  assign exIsBranchTakenPredicted = idValid && idPredTaken;
  assign exPredictedNextPc = idPredTaken ? idPredTarget : seqPc;
  assign exIrregPc = exBranchTaken ? idPc + idImm : seqPc;

  assign exRdAddr = idRdAddr;
  assign exWEnable = idValid && idRdWrEn;
  assign exIsForwardable = idOpcode != pipelineTypes::OP_LOAD;  // Load data comes a stage later

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      emValid <= 1'b0;
      emIsLoad <= 1'b0;
      emIsStore <= 1'b0;
      emRdWrEn <= 1'b0;
    end else begin
      emValid <= idValid;
      emIsLoad <= idValid && idOpcode == pipelineTypes::OP_LOAD;
      emIsStore <= idValid && idOpcode == pipelineTypes::OP_STORE;
      emRdWrEn <= idValid && idRdWrEn;
    end
  end

  always_ff @(posedge clk) begin
    emPc <= idPc;
    emResult <= aluOut;
    emStoreData <= op2;
    emRdAddr <= idRdAddr;
  end

endmodule

// ==== memoryStage.sv ====
`timescale 1ns/10ps

module memoryStage (
  input  logic                clk,
  input  logic                rstN,
  input  logic                emValid,
  input  basicTypes::wordT    emPc,
  input  basicTypes::wordT    emResult,
  input  basicTypes::wordT    emStoreData,
  input  logic                emIsLoad,
  input  logic                emIsStore,
  input  basicTypes::regAddrT emRdAddr,
  input  logic                emRdWrEn,
  output basicTypes::regAddrT memRdAddr,
  output logic                memWEnable,
  output logic                memIsForwardable,
  output basicTypes::wordT    memWbResult,
  output logic                wbEn,
  output basicTypes::regAddrT wbAddr,
  output basicTypes::wordT    wbData,
  output logic                retireValid,
  output basicTypes::wordT    retirePc,
  output logic                retireRdWrEn,
  output basicTypes::regAddrT retireRdAddr,
  output basicTypes::wordT    retireRdData,
  output logic                retireStoreEn,
  output basicTypes::wordT    retireStoreAddr,
  output basicTypes::wordT    retireStoreData
);

  basicTypes::wordT dmem [basicTypes::dmemDepth];
  logic [basicTypes::dmemIdxBits-1:0] dmemIdx;

  assign dmemIdx = emResult[basicTypes::dmemIdxBits+1:2];

  assign memRdAddr = emRdAddr;
  assign memWEnable = emRdWrEn;
  assign memIsForwardable = 1'b1;  // Data memory reads in this same cycle

  always_ff @(posedge clk) begin
    if (emIsStore) dmem[dmemIdx] <= emStoreData;
  end

  // MEM/WB feeds the register file and the retire report alike
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      retireValid <= 1'b0;
      retireRdWrEn <= 1'b0;
      retireStoreEn <= 1'b0;
    end else begin
      retireValid <= emValid;
      retireRdWrEn <= emRdWrEn;
      retireStoreEn <= emIsStore;
    end
  end

  always_ff @(posedge clk) begin
    retirePc <= emPc;
    retireRdAddr <= emRdAddr;
    retireRdData <= emIsLoad ? dmem[dmemIdx] : emResult;
    retireStoreAddr <= emResult;
    retireStoreData <= emStoreData;
  end

  assign memWbResult = retireRdData;
  assign wbEn = retireRdWrEn;
  assign wbAddr = retireRdAddr;
  assign wbData = retireRdData;

endmodule

// ==== tinyPipeCore.sv ====
`timescale 1ns/10ps

module tinyPipeCore (
  input  logic                clk,
  input  logic                rstN,
  input  logic                run,
  input  logic                imemWrEn,
  input  basicTypes::wordT    imemAddr,
  input  basicTypes::wordT    imemData,
  output logic                retireValid,
  output basicTypes::wordT    retirePc,
  output logic                retireRdWrEn,
  output basicTypes::regAddrT retireRdAddr,
  output basicTypes::wordT    retireRdData,
  output logic                retireStoreEn,
  output basicTypes::wordT    retireStoreAddr,
  output basicTypes::wordT    retireStoreData
);

  logic ifValid, ifPredTaken, predTaken, isDataHazard, isBranchPredictMiss;
  basicTypes::wordT lookupPc, ifPc, ifInstr, ifPredTarget, predTarget;
  basicTypes::opTypeE decAluOp2Type;
  logic decUsesRs1, decIsStore, decIsBranch;
  basicTypes::regAddrT decRs1Addr, decRs2Addr;
  pipelineTypes::bypassE op1BypassCtrl, op2BypassCtrl, idByp1, idByp2;
  logic idValid, idRdWrEn, idPredTaken, idBranchNe;
  basicTypes::wordT idPc, idRs1Data, idRs2Data, idImm, idPredTarget;
  basicTypes::regAddrT idRdAddr, exRdAddr, emRdAddr, memRdAddr, wbAddr;
  pipelineTypes::aluOpE idAluOp;
  pipelineTypes::opcodeE idOpcode;
  logic exWEnable, exIsForwardable, exBranchTaken, exIsBranchTakenPredicted, exIsBranch;
  basicTypes::wordT exPredictedNextPc, exIrregPc;
  logic emValid, emIsLoad, emIsStore, emRdWrEn;
  basicTypes::wordT emPc, emResult, emStoreData;
  logic memWEnable, memIsForwardable, wbEn;
  basicTypes::wordT memWbResult, wbData;

  fetchStage i_fetch (
    .stall(isDataHazard),
    .redirect(isBranchPredictMiss),
    .redirectPc(exIrregPc),
    .*
  );

  // Trained by every branch that resolves in execute
  branchPredictor i_predictor (
    .updateEn(exIsBranch),
    .updatePc(idPc),
    .updateTaken(exBranchTaken),
    .updateTarget(exIrregPc),
    .*
  );

  decodeStage i_decode (
    .stall(isDataHazard),
    .flush(isBranchPredictMiss),
    .*
  );

  hazardController i_hazard (.*);

  executeStage i_execute (
    .exMemResult(emResult),
    .*
  );

  memoryStage i_memory (.*);

endmodule

// ==== tbTinyPipe.sv ====
`timescale 1ns/10ps

module tbTinyPipe;

  logic clk;
  logic rstN;
  logic run;
  logic imemWrEn;
  basicTypes::wordT imemAddr;
  basicTypes::wordT imemData;
  logic retireValid;
  basicTypes::wordT retirePc;
  logic retireRdWrEn;
  basicTypes::regAddrT retireRdAddr;
  basicTypes::wordT retireRdData;
  logic retireStoreEn;
  basicTypes::wordT retireStoreAddr;
  basicTypes::wordT retireStoreData;

  // Program image and the retirement sequence the reference model expects
  basicTypes::wordT prog [basicTypes::imemDepth];
  int progLen;
  basicTypes::wordT expPc [64];
  logic expRdWrEn [64];
  basicTypes::regAddrT expRdAddr [64];
  basicTypes::wordT expRdData [64];
  logic expStoreEn [64];
  basicTypes::wordT expStoreAddr [64];
  basicTypes::wordT expStoreData [64];
  int expWait [64];  // Cycles from the previous retirement, or from run for the first
  int expCount;

  basicTypes::wordT refRegs [32];
  basicTypes::wordT refMem [basicTypes::dmemDepth];
  logic btbTaken [pipelineTypes::btbEntries];
  logic [26:0] btbTag [pipelineTypes::btbEntries];
  basicTypes::wordT btbTarget [pipelineTypes::btbEntries];

  logic [31:0] lfsr = 32'hf038;
  string testName;
  int retireIdx;
  int checkCount;

  tinyPipeCore i_dut (
    .clk(clk),
    .rstN(rstN),
    .run(run),
    .imemWrEn(imemWrEn),
    .imemAddr(imemAddr),
    .imemData(imemData),
    .retireValid(retireValid),
    .retirePc(retirePc),
    .retireRdWrEn(retireRdWrEn),
    .retireRdAddr(retireRdAddr),
    .retireRdData(retireRdData),
    .retireStoreEn(retireStoreEn),
    .retireStoreAddr(retireStoreAddr),
    .retireStoreData(retireStoreData)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Taps 32, 22, 2 and 1
  function automatic logic lfsrBit();
    logic fb;
    fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic logic [11:0] randImm();
    logic [11:0] v;
    int b;
    for (b = 0; b < 12; b++) v[b] = lfsrBit();
    return v;
  endfunction

  function automatic basicTypes::wordT aluR(input logic [2:0] f3, input logic alt,
      input basicTypes::regAddrT rd, input basicTypes::regAddrT rs1,
      input basicTypes::regAddrT rs2);
    return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, pipelineTypes::OP_REG};
  endfunction

  function automatic basicTypes::wordT addi(input basicTypes::regAddrT rd,
      input basicTypes::regAddrT rs1, input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, pipelineTypes::OP_IMM};
  endfunction

  function automatic basicTypes::wordT lw(input basicTypes::regAddrT rd,
      input basicTypes::regAddrT rs1, input logic [11:0] imm);
    return {imm, rs1, 3'b010, rd, pipelineTypes::OP_LOAD};
  endfunction

  function automatic basicTypes::wordT sw(input basicTypes::regAddrT rs2,
      input basicTypes::regAddrT rs1, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], pipelineTypes::OP_STORE};
  endfunction

  // funct3 000 is BEQ, 001 is BNE
  function automatic basicTypes::wordT branch(input logic [2:0] f3,
      input basicTypes::regAddrT rs1, input basicTypes::regAddrT rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], pipelineTypes::OP_BRANCH};
  endfunction

  task automatic emit(input basicTypes::wordT w);
    prog[progLen] = w;
    progLen++;
  endtask

  // Integer semantics of the RV32I register-register ops
  function automatic basicTypes::wordT aluRef(input logic [2:0] f3, input logic alt,
      input basicTypes::wordT a, input basicTypes::wordT b);
    case (f3)
      3'b000:  aluRef = alt ? a - b : a + b;
      3'b010:  aluRef = {31'b0, $signed(a) < $signed(b)};
      3'b100:  aluRef = a ^ b;
      3'b110:  aluRef = a | b;
      default: aluRef = a & b;
    endcase
  endfunction

  task automatic failRun(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic checkWord(input string name, input basicTypes::wordT got,
      input basicTypes::wordT exp);
    checkCount++;
    if (got !== exp) begin
      failRun($sformatf("MISMATCH %s: got 0x%h expected 0x%h (%s, retirement %0d)",
                        name, got, exp, testName, retireIdx));
    end
  endtask

  task automatic checkReg(input string name, input basicTypes::regAddrT got,
      input basicTypes::regAddrT exp);
    checkCount++;
    if (got !== exp) begin
      failRun($sformatf("MISMATCH %s: got 0x%h expected 0x%h (%s, retirement %0d)",
                        name, got, exp, testName, retireIdx));
    end
  endtask

  task automatic checkBit(input string name, input logic got, input logic exp);
    checkCount++;
    if (got !== exp) begin
      failRun($sformatf("MISMATCH %s: got 0x%h expected 0x%h (%s, retirement %0d)",
                        name, got, exp, testName, retireIdx));
    end
  endtask

  // Instruction-level interpreter with a BTB model that shows where the pipe loses cycles
  task automatic buildExpected();
    basicTypes::wordT pc;
    basicTypes::wordT w;
    basicTypes::wordT a;
    basicTypes::wordT b;
    basicTypes::wordT res;
    basicTypes::wordT addr;
    basicTypes::wordT target;
    basicTypes::wordT predNext;
    basicTypes::regAddrT rd;
    basicTypes::regAddrT rs1;
    basicTypes::regAddrT rs2;
    basicTypes::regAddrT loadRd;
    logic [2:0] f3;
    logic [2:0] idx;
    logic usesRs2;
    logic writesRd;
    logic taken;
    logic hit;
    logic prevMiss;
    int i;
    for (i = 0; i < 32; i++) refRegs[i] = '0;
    for (i = 0; i < pipelineTypes::btbEntries; i++) btbTaken[i] = 1'b0;
    pc = '0;
    loadRd = '0;
    prevMiss = 1'b0;
    expCount = 0;
    while (pc < basicTypes::wordT'(progLen * 4) && expCount < 64) begin
      w = prog[pc[7:2]];
      f3 = w[14:12];
      rd = w[11:7];
      rs1 = w[19:15];
      rs2 = w[24:20];
      a = refRegs[rs1];
      b = refRegs[rs2];
      usesRs2 = w[6:0] == pipelineTypes::OP_REG || w[6:0] == pipelineTypes::OP_STORE ||
                w[6:0] == pipelineTypes::OP_BRANCH;
      expWait[expCount] = (expCount == 0) ? 5 : 1;  // Five stages to fill first
      if (prevMiss) expWait[expCount] += 2;
      if (loadRd != '0 && (rs1 == loadRd || (usesRs2 && rs2 == loadRd))) begin
        expWait[expCount] += 1;  // Load-use bubble
      end
      expPc[expCount] = pc;
      expRdAddr[expCount] = rd;
      expStoreEn[expCount] = 1'b0;
      writesRd = 1'b1;
      loadRd = '0;
      prevMiss = 1'b0;
      res = '0;
      target = pc + 4;
      case (w[6:0])
        pipelineTypes::OP_REG: res = aluRef(f3, w[30], a, b);
        pipelineTypes::OP_IMM: res = a + {{20{w[31]}}, w[31:20]};
        pipelineTypes::OP_LOAD: begin
          addr = a + {{20{w[31]}}, w[31:20]};
          res = refMem[addr[7:2]];
          loadRd = rd;
        end
        pipelineTypes::OP_STORE: begin
          writesRd = 1'b0;
          addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
          refMem[addr[7:2]] = b;
          expStoreEn[expCount] = 1'b1;
          expStoreAddr[expCount] = addr;
          expStoreData[expCount] = b;
        end
        pipelineTypes::OP_BRANCH: begin
          writesRd = 1'b0;
          taken = (a == b) != f3[0];
          if (taken) target = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
          idx = pc[4:2];
          hit = btbTaken[idx] && btbTag[idx] == pc[31:5];
          predNext = hit ? btbTarget[idx] : pc + 4;
          prevMiss = (taken != hit) || (taken && hit && predNext != target);
          btbTaken[idx] = taken;
          btbTag[idx] = pc[31:5];
          btbTarget[idx] = target;
        end
        default: writesRd = 1'b0;
      endcase
      expRdWrEn[expCount] = writesRd && rd != '0;
      expRdData[expCount] = res;
      if (writesRd && rd != '0) refRegs[rd] = res;
      expCount++;
      pc = target;
    end
  endtask

  task automatic applyReset();
    @(posedge clk);
    #1;
    rstN = 1'b0;
    run = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    rstN = 1'b1;
  endtask

  task automatic runProgram(input string name);
    int waited;
    int i;
    testName = name;
    applyReset();
    // Unused words stay zero so the core fetches bubbles past the program
    for (i = 0; i < basicTypes::imemDepth; i++) begin
      @(posedge clk);
      #1;
      imemWrEn = 1'b1;
      imemAddr = i * 4;
      imemData = (i < progLen) ? prog[i] : '0;
    end
    buildExpected();
    @(posedge clk);
    #1;
    imemWrEn = 1'b0;
    run = 1'b1;
    for (i = 0; i < expCount; i++) begin
      retireIdx = i;
      waited = 0;
      do begin
        @(negedge clk);
        waited++;
        if (waited > 20) begin
          failRun($sformatf("%s: no retirement %0d within 20 cycles", name, i));
        end
      end while (!retireValid);
      if (waited != expWait[i]) begin
        failRun($sformatf("%s: retirement %0d came after %0d cycles instead of %0d",
                          name, i, waited, expWait[i]));
      end
      checkWord("retirePc", retirePc, expPc[i]);
      checkBit("retireRdWrEn", retireRdWrEn, expRdWrEn[i]);
      if (expRdWrEn[i]) begin
        checkReg("retireRdAddr", retireRdAddr, expRdAddr[i]);
        checkWord("retireRdData", retireRdData, expRdData[i]);
      end
      checkBit("retireStoreEn", retireStoreEn, expStoreEn[i]);
      if (expStoreEn[i]) begin
        checkWord("retireStoreAddr", retireStoreAddr, expStoreAddr[i]);
        checkWord("retireStoreData", retireStoreData, expStoreData[i]);
      end
    end
    // Nothing from a flushed path or past the end may retire
    retireIdx = expCount;
    repeat (6) begin
      @(negedge clk);
      checkBit("retireValid", retireValid, 1'b0);
    end
    @(posedge clk);
    #1;
    run = 1'b0;
  endtask

  task automatic independentAlu();
    progLen = 0;
    emit(addi(5'd1, 5'd0, randImm()));
    emit(addi(5'd2, 5'd0, randImm()));
    emit(addi(5'd3, 5'd0, randImm()));
    emit(addi(5'd4, 5'd0, randImm()));
    emit(aluR(3'b000, 1'b0, 5'd5, 5'd1, 5'd2));
    emit(aluR(3'b000, 1'b1, 5'd6, 5'd3, 5'd4));  // sub
    emit(aluR(3'b111, 1'b0, 5'd7, 5'd1, 5'd3));
    emit(aluR(3'b110, 1'b0, 5'd8, 5'd2, 5'd4));
    emit(aluR(3'b100, 1'b0, 5'd9, 5'd1, 5'd4));
    emit(aluR(3'b010, 1'b0, 5'd10, 5'd2, 5'd3));  // SLT in both orders
    emit(aluR(3'b010, 1'b0, 5'd11, 5'd3, 5'd2));
    emit(addi(5'd12, 5'd4, randImm()));
    runProgram("independent ALU ops");
  endtask

  task automatic dependencyChains();
    progLen = 0;
    emit(addi(5'd1, 5'd0, randImm()));
    emit(addi(5'd2, 5'd1, randImm()));          // rs1 at distance 1
    emit(aluR(3'b000, 1'b0, 5'd3, 5'd0, 5'd2));  // rs2 at distance 1
    emit(aluR(3'b100, 1'b0, 5'd4, 5'd1, 5'd0));  // rs1 at distance 3
    emit(aluR(3'b000, 1'b1, 5'd5, 5'd3, 5'd2));
    emit(aluR(3'b110, 1'b0, 5'd6, 5'd4, 5'd3));
    emit(aluR(3'b111, 1'b0, 5'd0, 5'd5, 5'd6));  // Write to x0 is dropped
    emit(aluR(3'b010, 1'b0, 5'd7, 5'd0, 5'd6));  // rs2 at distance 2
    emit(aluR(3'b000, 1'b0, 5'd8, 5'd0, 5'd6));
    emit(addi(5'd9, 5'd7, randImm()));
    emit(aluR(3'b000, 1'b0, 5'd10, 5'd8, 5'd9));
    runProgram("dependency chains");
  endtask

  task automatic loadUseAndStore();
    progLen = 0;
    emit(addi(5'd1, 5'd0, randImm()));
    emit(addi(5'd2, 5'd0, 12'd16));
    emit(sw(5'd1, 5'd2, 12'd0));
    emit(lw(5'd3, 5'd2, 12'd0));
    emit(aluR(3'b000, 1'b0, 5'd4, 5'd3, 5'd1));  // Uses the load on rs1
    emit(aluR(3'b100, 1'b0, 5'd5, 5'd4, 5'd1));
    emit(sw(5'd5, 5'd2, 12'd4));
    emit(lw(5'd6, 5'd2, 12'd4));
    emit(aluR(3'b000, 1'b1, 5'd7, 5'd1, 5'd6));  // Uses the load on rs2
    emit(lw(5'd8, 5'd2, 12'd0));
    emit(addi(5'd9, 5'd0, randImm()));
    emit(aluR(3'b000, 1'b0, 5'd10, 5'd8, 5'd9));
    emit(lw(5'd11, 5'd2, 12'd4));
    emit(sw(5'd11, 5'd2, 12'd8));  // Store data straight from a load
    emit(lw(5'd12, 5'd2, 12'd8));
    runProgram("loads and stores");
  endtask

  task automatic loopBranch();
    progLen = 0;
    emit(addi(5'd1, 5'd0, 12'd4));
    emit(addi(5'd2, 5'd0, randImm()));
    emit(aluR(3'b000, 1'b0, 5'd2, 5'd2, 5'd1));
    emit(addi(5'd1, 5'd1, 12'hfff));
    emit(branch(3'b001, 5'd1, 5'd0, 13'h1ff8));  // BNE back by two words
    emit(addi(5'd3, 5'd2, 12'd1));
    emit(aluR(3'b000, 1'b1, 5'd4, 5'd3, 5'd1));
    runProgram("BNE loop");
  endtask

  task automatic fallThroughBeq();
    progLen = 0;
    emit(addi(5'd1, 5'd0, randImm()));
    emit(addi(5'd2, 5'd1, 12'd1));
    emit(branch(3'b000, 5'd1, 5'd2, 13'd8));
    emit(addi(5'd3, 5'd1, 12'd2));
    emit(branch(3'b000, 5'd2, 5'd3, 13'd8));
    emit(aluR(3'b000, 1'b0, 5'd4, 5'd3, 5'd2));
    emit(addi(5'd5, 5'd4, randImm()));
    runProgram("BEQ fall-through");
  endtask

  initial begin
    rstN = 1'b0;
    run = 1'b0;
    imemWrEn = 1'b0;
    imemAddr = '0;
    imemData = '0;
    checkCount = 0;
    independentAlu();
    dependencyChains();
    loadUseAndStore();
    loopBranch();
    fallThroughBeq();
    if (checkCount > 0) begin
      $display("Test passed");
      $finish;
    end else begin
      $display("No retirement was checked");
      $display("Test failed");
      $fatal(1);
    end
  end

endmodule

// ==== tinyPipe.f ====
basicTypes.sv
pipelineTypes.sv
hazardController.sv
branchPredictor.sv
fetchStage.sv
decodeStage.sv
executeStage.sv
memoryStage.sv
tinyPipeCore.sv
tbTinyPipe.sv

// ==== Makefile ====
TOP ?= tbTinyPipe
FILELIST ?= tinyPipe.f
VERILATOR ?= verilator
VFLAGS ?= --binary --timing
OBJDIR ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Test passed"

clean:
	rm -rf $(OBJDIR)
